/* common/aes_pkg.sv */
`default_nettype none

package aes_pkg;

	localparam int block_width = 128;
	localparam int fifo_depth  = 4;
	localparam int num_rounds  = 10;

	typedef enum logic {
		cmd_ecb_enc,
		cmd_cbc_enc
	} aes_cmd_e;

	typedef enum logic [2:0] {
		st_get_key = 3'b010,
		st_get_iv  = 3'b011,
		st_start   = 3'b101,
		st_wait    = 3'b110,
		st_store   = 3'b111
	} ctrl_state_e;

	// ============================================================
	// Forward S-box, entry 0 in the top byte.
	// ============================================================
	localparam logic [2047:0] sbox_table = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	function automatic logic [7:0] sbox(input logic [7:0] b);
		return sbox_table[2047 - 8 * int'(b) -: 8];
	endfunction

	// Multiply by x in GF(2^8) with the AES polynomial.
	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

endpackage

`default_nettype wire

/* aes_core/aes_cipher.sv */
`default_nettype none

module aes_cipher import aes_pkg::*; (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    start,
	input  wire  [block_width-1:0] key,
	input  wire  [block_width-1:0] block,
	output logic                   busy,
	output logic                   done,
	output logic [block_width-1:0] result
);

	logic [block_width-1:0] aes_state;
	logic [block_width-1:0] round_key;
	logic [block_width-1:0] key_next;
	logic [block_width-1:0] shifted;
	logic [block_width-1:0] round_out;
	logic [7:0]             rcon;
	logic [3:0]             round;
	logic                   last_round;

	// ============================================================
	// Round functions. Byte 0 of the state sits in the top byte.
	// ============================================================
	function automatic logic [block_width-1:0] sub_bytes(input logic [block_width-1:0] s);
		logic [block_width-1:0] o;
		for (int i = 0; i < 16; i++) begin
			o[8*i +: 8] = sbox(s[8*i +: 8]);
		end
		return o;
	endfunction

	// Row r of column c takes the byte from column c + r.
	function automatic logic [block_width-1:0] shift_rows(input logic [block_width-1:0] s);
		logic [block_width-1:0] o;
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				o[block_width-1-8*(4*c+r) -: 8] = s[block_width-1-8*(4*((c+r)%4)+r) -: 8];
			end
		end
		return o;
	endfunction

	function automatic logic [block_width-1:0] mix_columns(input logic [block_width-1:0] s);
		logic [block_width-1:0] o;
		logic [31:0]            w;
		logic [7:0]             a0, a1, a2, a3;
		for (int c = 0; c < 4; c++) begin
			w  = s[block_width-1-32*c -: 32];
			a0 = w[31:24];
			a1 = w[23:16];
			a2 = w[15:8];
			a3 = w[7:0];
			o[block_width-1-32*c -: 32] = {
				xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
				a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
				a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
				xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)
			};
		end
		return o;
	endfunction

	// One step of the key schedule with RotWord, SubWord and rcon.
	function automatic logic [block_width-1:0] expand_key(input logic [block_width-1:0] k,
			input logic [7:0] rc);
		logic [31:0] w0, w1, w2, w3, t;
		w0 = k[127:96];
		w3 = k[31:0];
		t  = {sbox(w3[23:16]), sbox(w3[15:8]), sbox(w3[7:0]), sbox(w3[31:24])};
		w0 = w0 ^ t ^ {rc, 24'h0};
		w1 = k[95:64] ^ w0;
		w2 = k[63:32] ^ w1;
		w3 = w3 ^ w2;
		return {w0, w1, w2, w3};
	endfunction

	assign last_round = (round == 4'(num_rounds));
	assign key_next   = expand_key(round_key, rcon);
	assign shifted    = shift_rows(sub_bytes(aes_state));
	assign round_out  = (last_round ? shifted : mix_columns(shifted)) ^ key_next;
	assign result     = aes_state; // Held until the next start.

	always_ff @(posedge clk) begin
		if (reset) begin
			busy  <= 1'b0;
			done  <= 1'b0;
			round <= 4'd0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy  <= 1'b1;
				round <= 4'd1;
			end else if (busy) begin
				round <= round + 4'd1;
				if (last_round) begin
					busy <= 1'b0;
					done <= 1'b1; // Eleven cycles after start.
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			aes_state <= block ^ key; // Initial AddRoundKey.
			round_key <= key;
			rcon      <= 8'h01;
		end else if (busy) begin
			aes_state <= round_out;
			round_key <= key_next;
			rcon      <= xtime(rcon);
		end
	end

endmodule

`default_nettype wire

/* design/stream_fifo.sv */
`default_nettype none

module stream_fifo import aes_pkg::*; #(
	parameter int DEPTH = 4
) (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    wr_valid,
	output logic                   wr_ready,
	input  wire  [block_width-1:0] wr_data,
	output logic                   rd_valid,
	input  wire                    rd_ready,
	output logic [block_width-1:0] rd_data,
	output logic                   empty
);

	logic [block_width-1:0]     mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH):0]     count;
	logic [$clog2(DEPTH):0]     count_next;
	logic                       push;
	logic                       pop;

	assign push       = wr_valid && wr_ready;
	assign pop        = rd_valid && rd_ready;
	assign count_next = count + push - pop;

	assign empty    = (count == '0);
	assign rd_valid = !empty;
	assign rd_data  = mem[rd_ptr];

	// Ready is registered so that it stays low through reset.
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			wr_ready <= 1'b0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1; // Pointers wrap at a power of two.
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			count    <= count_next;
			wr_ready <= (count_next != ($clog2(DEPTH)+1)'(DEPTH));
		end
	end

	always_ff @(posedge clk) begin
		if (push) mem[wr_ptr] <= wr_data;
	end

endmodule

`default_nettype wire

/* design/aes_controller.sv */
`default_nettype none

module aes_controller import aes_pkg::*; (
	input  wire                    clk,
	input  wire                    reset,
	input  wire  aes_cmd_e         cmd,
	input  wire                    input_done,

	// Input FIFO read side.
	input  wire                    in_valid,
	output logic                   in_ready,
	input  wire  [block_width-1:0] in_data,
	input  wire                    in_empty,

	// Output FIFO write side.
	output logic                   out_valid,
	input  wire                    out_ready,
	output logic [block_width-1:0] out_data,

	// Cipher core.
	output logic                   start,
	output logic [block_width-1:0] key,
	output logic [block_width-1:0] block,
	input  wire                    busy,
	input  wire                    done,
	input  wire  [block_width-1:0] result,

	output logic                   processing_done
);

	ctrl_state_e            state;
	logic [block_width-1:0] chain;
	logic                   in_fire;
	logic                   out_fire;
	logic                   cbc_mode;

	assign in_fire  = in_valid && in_ready;
	assign out_fire = out_valid && out_ready;
	assign cbc_mode = (cmd == cmd_cbc_enc);

	// ============================================================
	// Session FSM
	// ============================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state           <= st_get_key;
			in_ready        <= 1'b0;
			start           <= 1'b0;
			out_valid       <= 1'b0;
			processing_done <= 1'b0;
		end else begin
			in_ready <= 1'b0;
			start    <= 1'b0;

			case (state)
				st_get_key: begin
					in_ready <= 1'b1;
					if (in_fire) begin
						in_ready        <= 1'b0;
						processing_done <= 1'b0;
						state           <= cbc_mode ? st_get_iv : st_start;
					end
				end
				st_get_iv: begin
					in_ready <= 1'b1;
					if (in_fire) begin
						in_ready <= 1'b0;
						state    <= st_start;
					end
				end
				st_start: begin
					if (!busy) in_ready <= 1'b1;
					if (in_fire) begin
						in_ready <= 1'b0;
						start    <= 1'b1; // Core sees the block one cycle later.
						state    <= st_wait;
					end else if (input_done && in_empty) begin
						in_ready        <= 1'b0;
						processing_done <= 1'b1;
						state           <= st_get_key;
					end
				end
				st_wait: begin
					if (done) begin
						out_valid <= 1'b1;
						state     <= st_store;
					end
				end
				st_store: begin
					// Stays here under back-pressure, so no new block is read.
					if (out_fire) begin
						out_valid <= 1'b0;
						state     <= st_start;
					end
				end
				default: state <= st_get_key;
			endcase
		end
	end

	// ============================================================
	// Key, chaining value and block registers
	// ============================================================
	always_ff @(posedge clk) begin
		if (in_fire) begin
			case (state)
				st_get_key: key <= in_data;
				st_get_iv: chain <= in_data;
				st_start: block <= cbc_mode ? (in_data ^ chain) : in_data;
				default: ;
			endcase
		end
		if (state == st_wait && done) begin
			out_data <= result;
			if (cbc_mode) chain <= result; // Next block chains on this ciphertext.
		end
	end

endmodule

`default_nettype wire

/* design/aes_stream_top.sv */
`default_nettype none

module aes_stream_top import aes_pkg::*; (
	input  wire                    clk,
	input  wire                    reset,
	input  wire  aes_cmd_e         cmd,
	input  wire                    input_done,
	input  wire                    s_tvalid,
	output logic                   s_tready,
	input  wire  [block_width-1:0] s_tdata,
	output logic                   m_tvalid,
	input  wire                    m_tready,
	output logic [block_width-1:0] m_tdata,
	output logic                   processing_done
);

	logic                   in_valid;
	logic                   in_ready;
	logic [block_width-1:0] in_data;
	logic                   in_empty;
	logic                   out_valid;
	logic                   out_ready;
	logic [block_width-1:0] out_data;
	logic                   start;
	logic [block_width-1:0] key;
	logic [block_width-1:0] block;
	logic                   busy;
	logic                   done;
	logic [block_width-1:0] result;

	stream_fifo #(.DEPTH(fifo_depth)) in_fifo_i (
		.clk      (clk),
		.reset    (reset),
		.wr_valid (s_tvalid),
		.wr_ready (s_tready),
		.wr_data  (s_tdata),
		.rd_valid (in_valid),
		.rd_ready (in_ready),
		.rd_data  (in_data),
		.empty    (in_empty)
	);

	aes_controller ctrl_i (
		.clk             (clk),
		.reset           (reset),
		.cmd             (cmd),
		.input_done      (input_done),
		.in_valid        (in_valid),
		.in_ready        (in_ready),
		.in_data         (in_data),
		.in_empty        (in_empty),
		.out_valid       (out_valid),
		.out_ready       (out_ready),
		.out_data        (out_data),
		.start           (start),
		.key             (key),
		.block           (block),
		.busy            (busy),
		.done            (done),
		.result          (result),
		.processing_done (processing_done)
	);

	aes_cipher core_i (
		.clk    (clk),
		.reset  (reset),
		.start  (start),
		.key    (key),
		.block  (block),
		.busy   (busy),
		.done   (done),
		.result (result)
	);

	// The output FIFO's empty flag has no user.
	stream_fifo #(.DEPTH(fifo_depth)) out_fifo_i (
		.clk      (clk),
		.reset    (reset),
		.wr_valid (out_valid),
		.wr_ready (out_ready),
		.wr_data  (out_data),
		.rd_valid (m_tvalid),
		.rd_ready (m_tready),
		.rd_data  (m_tdata),
		.empty    ()
	);

endmodule

`default_nettype wire

/* tests/aes_stream_chk.sv */
`default_nettype none

module aes_stream_chk import aes_pkg::*; (
	input wire                   clk,
	input wire                   reset,
	input wire                   s_tready,
	input wire                   m_tvalid,
	input wire                   m_tready,
	input wire [block_width-1:0] m_tdata,
	input wire                   start,
	input wire                   busy,
	input wire                   done
);

	int fail_count = 0;

	// A stalled output word keeps its valid and its data.
	assert property (@(posedge clk) disable iff (reset)
		m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata))
		else begin
			fail_count++;
			$error("output stream changed while m_tready was low");
		end

	assert property (@(posedge clk) disable iff (reset)
		start |=> !done [*num_rounds] ##1 done) // One cycle per round plus the load.
		else begin
			fail_count++;
			$error("core done did not follow start by %0d cycles", num_rounds + 1);
		end

	assert property (@(posedge clk) disable iff (reset) start |-> !busy)
		else begin
			fail_count++;
			$error("core started while it was busy");
		end

	// The input FIFO holds the source off through reset.
	assert property (@(posedge clk) reset |=> !s_tready)
		else begin
			fail_count++;
			$error("s_tready high during reset");
		end

endmodule

`default_nettype wire

/* tests/aes_stream_tb.sv */
`default_nettype none

module aes_stream_tb import aes_pkg::*; ();

	localparam int timeout_cycles = 300;
	localparam logic [block_width-1:0] ref_key = 128'h000102030405060708090a0b0c0d0e0f;
	localparam logic [block_width-1:0] ref_pt  = 128'h00112233445566778899aabbccddeeff;
	localparam logic [block_width-1:0] ref_ct  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam logic [block_width-1:0] iv_a    = 128'hf0e1d2c3b4a5968778695a4b3c2d1e0f;
	localparam logic [block_width-1:0] iv_b    = 128'h3243f6a8885a308d313198a2e0370734;
	// ECB vectors from SP 800-38A, so that the order of outputs is visible.
	localparam logic [block_width-1:0] sp_key  = 128'h2b7e151628aed2a6abf7158809cf4f3c;

	logic                   clk = 1'b0;
	logic                   reset;
	aes_cmd_e               cmd;
	logic                   input_done;
	logic                   s_tvalid;
	logic                   s_tready;
	logic [block_width-1:0] s_tdata;
	logic                   m_tvalid;
	logic                   m_tready;
	logic [block_width-1:0] m_tdata;
	logic                   processing_done;

	logic [15:0]            lfsr_state = 16'd10;
	logic [block_width-1:0] word_q[$];
	logic [block_width-1:0] exp_q[$];
	int                     errors = 0;
	int                     tests_run = 0;
	int                     tests_failed = 0;

	aes_stream_top dut_i (
		.clk             (clk),
		.reset           (reset),
		.cmd             (cmd),
		.input_done      (input_done),
		.s_tvalid        (s_tvalid),
		.s_tready        (s_tready),
		.s_tdata         (s_tdata),
		.m_tvalid        (m_tvalid),
		.m_tready        (m_tready),
		.m_tdata         (m_tdata),
		.processing_done (processing_done)
	);

	bind aes_stream_top aes_stream_chk chk_i (
		.clk      (clk),
		.reset    (reset),
		.s_tready (s_tready),
		.m_tvalid (m_tvalid),
		.m_tready (m_tready),
		.m_tdata  (m_tdata),
		.start    (start),
		.busy     (busy),
		.done     (done)
	);

	always #10 clk = ~clk;

	// Taps 16, 14, 13 and 11, shifting toward bit 0.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
	endfunction

	task automatic report_mismatch(input string name, input logic [block_width-1:0] exp,
			input logic [block_width-1:0] act);
		$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
		errors++;
	endtask

	task automatic report_failure(input string what);
		$display("ERROR at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %-12s ok", name);
		end else begin
			$display("test %-12s failed with %0d errors", name, errors - errors_before);
			tests_failed++;
		end
	endtask

	// ============================================================
	// Stream drivers
	// ============================================================
	task automatic send_words();
		int wait_cycles;
		while (word_q.size() > 0) begin
			s_tvalid <= 1'b1;
			s_tdata  <= word_q.pop_front();
			wait_cycles = 0;
			@(posedge clk);
			while (!s_tready && wait_cycles < timeout_cycles) begin
				wait_cycles++;
				@(posedge clk);
			end
			if (!s_tready) report_failure("input stream did not accept a word");
		end
		s_tvalid <= 1'b0;
	endtask

	task automatic collect_blocks(input int count, input bit gaps);
		int                     got;
		int                     idle;
		logic [block_width-1:0] expected;
		got  = 0;
		idle = 0;
		while (got < count && idle < timeout_cycles) begin
			if (gaps) begin
				lfsr_state = lfsr_next(lfsr_state);
				m_tready <= lfsr_state[0];
			end else begin
				m_tready <= 1'b1;
			end
			@(posedge clk);
			if (m_tvalid && m_tready) begin
				expected = exp_q.pop_front();
				if (m_tdata !== expected) report_mismatch("m_tdata", expected, m_tdata);
				got++;
				idle = 0;
			end else begin
				idle++;
			end
		end
		m_tready <= 1'b0;
		if (got < count) report_failure("output stream delivered too few blocks");
	endtask

	// Runs one session from the queued words and closes it with input_done.
	task automatic run_session(input aes_cmd_e mode, input bit gaps);
		int count;
		int wait_cycles;
		count = exp_q.size();
		cmd        <= mode;
		input_done <= 1'b0;
		@(posedge clk);
		fork
			send_words();
			collect_blocks(count, gaps);
		join
		if (processing_done !== 1'b0) report_mismatch("processing_done", 0, processing_done);
		input_done <= 1'b1;
		wait_cycles = 0;
		@(posedge clk);
		while (!processing_done && wait_cycles < timeout_cycles) begin
			wait_cycles++;
			@(posedge clk);
		end
		if (!processing_done) report_failure("processing_done did not rise after input_done");
		if (m_tvalid !== 1'b0) report_mismatch("m_tvalid", 0, m_tvalid); // Extra output block.
		input_done <= 1'b0;
		@(posedge clk);
	endtask

	// ============================================================
	// Tests
	// ============================================================
	task automatic test_reset();
		int errors_before;
		int cycle;
		errors_before = errors;
		for (cycle = 1; cycle <= 6; cycle++) begin
			@(posedge clk);
			if (cycle == 4) reset <= 1'b0;
			if (cycle > 1 && m_tvalid !== 1'b0) report_mismatch("m_tvalid", 0, m_tvalid);
			if (cycle > 1 && processing_done !== 1'b0)
				report_mismatch("processing_done", 0, processing_done);
		end
		report_test("reset", errors_before);
	endtask

	task automatic test_ecb();
		int errors_before;
		errors_before = errors;
		word_q = '{ref_key, ref_pt, ref_pt};
		exp_q  = '{ref_ct, ref_ct};
		run_session(cmd_ecb_enc, 1'b0);
		report_test("ecb", errors_before);
	endtask

	// Each CBC input is chosen so that the chained block equals the reference plaintext.
	task automatic test_cbc();
		int errors_before;
		errors_before = errors;
		word_q = '{ref_key, iv_a, ref_pt ^ iv_a, ref_pt ^ ref_ct};
		exp_q  = '{ref_ct, ref_ct};
		run_session(cmd_cbc_enc, 1'b0);
		report_test("cbc", errors_before);
	endtask

	task automatic test_backpressure();
		int errors_before;
		errors_before = errors;
		word_q = '{sp_key,
			128'h6bc1bee22e409f96e93d7e117393172a, 128'hae2d8a571e03ac9c9eb76fac45af8e51,
			128'h30c81c46a35ce411e5fbc1191a0a52ef, 128'hf69f2445df4f9b17ad2b417be66c3710};
		exp_q  = '{128'h3ad77bb40d7a3660a89ecaf32466ef97, 128'hf5d3d58503b9699de785895a96fdbaaf,
			128'h43b1cd7f598ece23881b00e3ed030688, 128'h7b0c785e27e8ad3f8223207104725dd4};
		run_session(cmd_ecb_enc, 1'b1);
		report_test("backpressure", errors_before);
	endtask

	task automatic test_restart();
		int errors_before;
		errors_before = errors;
		word_q = '{ref_key, iv_b, ref_pt ^ iv_b, ref_pt ^ ref_ct, ref_pt ^ ref_ct};
		exp_q  = '{ref_ct, ref_ct, ref_ct};
		run_session(cmd_cbc_enc, 1'b0);
		report_test("restart", errors_before);
	endtask

	initial begin
		reset      <= 1'b1;
		cmd        <= cmd_ecb_enc;
		input_done <= 1'b0;
		s_tvalid   <= 1'b0;
		s_tdata    <= '0;
		m_tready   <= 1'b0;
		test_reset();
		test_ecb();
		test_cbc();
		test_backpressure();
		test_restart();
		if (dut_i.chk_i.fail_count != 0) report_failure("checker assertions failed");
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
common/aes_pkg.sv
aes_core/aes_cipher.sv
design/stream_fifo.sv
design/aes_controller.sv
design/aes_stream_top.sv
tests/aes_stream_chk.sv
tests/aes_stream_tb.sv
